//--- logic/trace_pkg.sv
// instruction trace package
// shared widths, opcode constants, instruction classes and record types

package trace_pkg;

  localparam int xlen    = 32;
  localparam int cycle_w = 32;

  ////////////////////////////////////////////////////////////////////////////
  // base opcodes
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [6:0] opcode_lui    = 7'b0110111;
  localparam logic [6:0] opcode_auipc  = 7'b0010111;
  localparam logic [6:0] opcode_jal    = 7'b1101111;
  localparam logic [6:0] opcode_jalr   = 7'b1100111;
  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_load   = 7'b0000011;
  localparam logic [6:0] opcode_store  = 7'b0100011;
  localparam logic [6:0] opcode_opimm  = 7'b0010011;
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_system = 7'b1110011;
  localparam logic [6:0] opcode_fence  = 7'b0001111;

  typedef logic [4:0] reg_addr_t;

  typedef enum logic [3:0] {
    class_u       = 4'd0,
    class_j       = 4'd1,
    class_i       = 4'd2,
    class_b       = 4'd3,
    class_s       = 4'd4,
    class_r       = 4'd5,
    class_load    = 4'd6,
    class_system  = 4'd7,
    class_fence   = 4'd8,
    class_invalid = 4'd9
  } iclass_e;

  ////////////////////////////////////////////////////////////////////////////
  // core-side ports and trace record
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic            we;
    reg_addr_t       addr;
    logic [xlen-1:0] wdata;
  } reg_wr_t;

  typedef struct packed {
    logic            req;
    logic            gnt;
    logic            we;
    logic [xlen-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic [cycle_w-1:0] cycle;
    logic [xlen-1:0]    pc;
    logic [xlen-1:0]    instr;
    iclass_e            iclass;
    reg_addr_t          rd;
    // instruction writes a nonzero rd
    logic               rd_valid;
    // a write to rd was observed
    logic               rd_seen;
    logic [xlen-1:0]    rd_wdata;
    logic               mem_valid;
    logic               mem_we;
    logic [xlen-1:0]    mem_addr;
  } trace_rec_t;

endpackage

//--- logic/trace_ctrl.sv
// tracer control
// start-up FSM plus EX/WB occupancy, producing load and retire strobes

module trace_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic fetch_enable,
  input  logic id_valid,
  input  logic is_decoding,
  input  logic ex_valid,
  input  logic wb_bypass,
  input  logic wb_valid,
  output logic count_en,
  output logic ex_load,
  output logic ex_busy,
  output logic wb_load,
  output logic wb_busy,
  output logic emit_ex,
  output logic emit_wb
);

  typedef enum logic {
    st_idle,
    st_running
  } state_e;

  state_e state;
  logic   ex_leave;

  // tracing starts on the first fetch_enable after reset and stays on
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else if (state == st_idle && fetch_enable) begin
      state <= st_running;
    end
  end

  assign count_en = (state == st_running);
  assign ex_load  = count_en && id_valid && is_decoding;

  // stage advance rules
  assign ex_leave = ex_busy && (ex_valid || wb_bypass);
  assign emit_ex  = ex_leave && wb_bypass;
  assign wb_load  = ex_leave && !wb_bypass;
  assign emit_wb  = wb_busy && wb_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_busy <= 1'b0;
      wb_busy <= 1'b0;
    end else begin
      if (ex_load) begin
        ex_busy <= 1'b1;
      end else if (ex_leave) begin
        ex_busy <= 1'b0;
      end
      if (wb_load) begin
        wb_busy <= 1'b1;
      end else if (emit_wb) begin
        wb_busy <= 1'b0;
      end
    end
  end

  // one instruction per stage, so EX must drain before the next capture
  assert property (@(posedge clk) disable iff (!rst_n)
    ex_load |-> (!ex_busy || ex_leave))
    else $error("capture while EX slot is held");

  // single output register, only one retirement per cycle
  assert property (@(posedge clk) disable iff (!rst_n)
    emit_ex |-> !emit_wb)
    else $error("retirement from EX and WB in the same cycle");

endmodule

//--- logic/cycle_counter.sv
// cycle stamp counter
// cleared by reset, advances every cycle while enabled

module cycle_counter #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             count_en,
  output logic [WIDTH-1:0] count
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (count_en) begin
      count <= count + 1'b1;
    end
  end

endmodule

//--- logic/instr_classifier.sv
// instruction classifier
// maps opcode and funct3 to a class, extracts rd

module instr_classifier (
  input  logic [trace_pkg::xlen-1:0] instr,
  output trace_pkg::iclass_e         iclass,
  output trace_pkg::reg_addr_t       rd,
  output logic                       rd_valid
);

  import trace_pkg::*;

  logic [2:0] funct3;
  logic       writes_rd;

  assign funct3 = instr[14:12];
  assign rd     = instr[11:7];

  always_comb begin
    iclass = class_invalid;
    case (instr[6:0])
      opcode_lui,
      opcode_auipc:  iclass = class_u;
      opcode_jal:    iclass = class_j;
      opcode_jalr,
      opcode_opimm:  iclass = class_i;
      opcode_branch: iclass = class_b;
      opcode_op:     iclass = class_r;
      opcode_system: iclass = class_system;
      opcode_fence:  iclass = class_fence;
      // lb, lh, lw, lbu, lhu only
      opcode_load: begin
        if (funct3 == 3'd3 || funct3 == 3'd6 || funct3 == 3'd7) begin
          iclass = class_invalid;
        end else begin
          iclass = class_load;
        end
      end
      // sb, sh, sw only
      opcode_store:  iclass = (funct3 < 3'd3) ? class_s : class_invalid;
      default:       iclass = class_invalid;
    endcase
  end

  // classes with a destination register
  assign writes_rd = (iclass == class_u) || (iclass == class_j) ||
                     (iclass == class_i) || (iclass == class_r) ||
                     (iclass == class_load) || (iclass == class_system);

  assign rd_valid = writes_rd && (rd != '0);

endmodule

//--- logic/ex_slot.sv
// EX stage trace entry
// collects the rd write and the first granted data access while in EX

module ex_slot (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          ex_load,
  input  logic                          ex_busy,
  input  logic [trace_pkg::xlen-1:0]    pc,
  input  logic [trace_pkg::xlen-1:0]    instr,
  input  logic [trace_pkg::cycle_w-1:0] cycle,
  input  trace_pkg::iclass_e            iclass,
  input  trace_pkg::reg_addr_t          rd,
  input  logic                          rd_valid,
  input  trace_pkg::reg_wr_t            ex_wr,
  input  trace_pkg::mem_req_t           ex_mem,
  output trace_pkg::trace_rec_t         ex_next
);

  import trace_pkg::*;

  trace_rec_t fresh;
  trace_rec_t ex_q;

  // new record at capture, nothing observed yet
  always_comb begin
    fresh           = '0;
    fresh.cycle     = cycle;
    fresh.pc        = pc;
    fresh.instr     = instr;
    fresh.iclass    = iclass;
    fresh.rd        = rd;
    fresh.rd_valid  = rd_valid;
  end

  // held entry plus this cycle's events
  always_comb begin
    ex_next = ex_q;
    // only instructions with a real rd pick up writes
    if (ex_q.rd_valid && ex_wr.we && ex_wr.addr == ex_q.rd) begin
      ex_next.rd_seen  = 1'b1;
      ex_next.rd_wdata = ex_wr.wdata;
    end
    if (!ex_q.mem_valid && ex_mem.req && ex_mem.gnt) begin
      ex_next.mem_valid = 1'b1;
      ex_next.mem_we    = ex_mem.we;
      ex_next.mem_addr  = ex_mem.addr;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_q <= '0;
    end else if (ex_load) begin
      ex_q <= fresh;
    end else if (ex_busy) begin
      ex_q <= ex_next;
    end
  end

endmodule

//--- logic/retire_slot.sv
// WB stage trace entry and registered trace output
// takes rd writes in WB, emits one record per retirement

module retire_slot (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wb_load,
  input  logic                  wb_busy,
  input  logic                  emit_ex,
  input  logic                  emit_wb,
  input  trace_pkg::trace_rec_t ex_next,
  input  trace_pkg::reg_wr_t    wb_wr,
  output logic                  trace_valid,
  output trace_pkg::trace_rec_t trace_rec
);

  import trace_pkg::*;

  trace_rec_t wb_q;
  trace_rec_t wb_next;

  always_comb begin
    wb_next = wb_q;
    if (wb_q.rd_valid && wb_wr.we && wb_wr.addr == wb_q.rd) begin
      wb_next.rd_seen  = 1'b1;
      wb_next.rd_wdata = wb_wr.wdata;
    end
  end

  // WB entry
  always_ff @(posedge clk) begin
    if (wb_load) begin
      wb_q <= ex_next;
    end else if (wb_busy) begin
      wb_q <= wb_next;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trace_valid <= 1'b0;
    end else begin
      trace_valid <= emit_ex || emit_wb;
    end
  end

  // bypassed instructions come straight from EX
  always_ff @(posedge clk) begin
    if (emit_ex) begin
      trace_rec <= ex_next;
    end else if (emit_wb) begin
      trace_rec <= wb_next;
    end
  end

endmodule

//--- logic/trace_top.sv
// instruction retirement tracer
// follows each decoded instruction through EX and WB, one record per retire

module trace_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fetch_enable,
  input  logic [31:0]           pc,
  input  logic [31:0]           instr,
  input  logic                  id_valid,
  input  logic                  is_decoding,
  input  logic                  ex_valid,
  input  trace_pkg::reg_wr_t    ex_wr,
  input  trace_pkg::mem_req_t   ex_mem,
  input  logic                  wb_bypass,
  input  logic                  wb_valid,
  input  trace_pkg::reg_wr_t    wb_wr,
  output logic                  trace_valid,
  output trace_pkg::trace_rec_t trace_rec
);

  import trace_pkg::*;

  logic               count_en;
  logic               ex_load;
  logic               ex_busy;
  logic               wb_load;
  logic               wb_busy;
  logic               emit_ex;
  logic               emit_wb;
  iclass_e            iclass;
  reg_addr_t          rd;
  logic               rd_valid;
  logic [cycle_w-1:0] cycle;
  trace_rec_t         ex_next;

  trace_ctrl trace_ctrl_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_enable (fetch_enable),
    .id_valid     (id_valid),
    .is_decoding  (is_decoding),
    .ex_valid     (ex_valid),
    .wb_bypass    (wb_bypass),
    .wb_valid     (wb_valid),
    .count_en     (count_en),
    .ex_load      (ex_load),
    .ex_busy      (ex_busy),
    .wb_load      (wb_load),
    .wb_busy      (wb_busy),
    .emit_ex      (emit_ex),
    .emit_wb      (emit_wb)
  );

  cycle_counter #(
    .WIDTH (cycle_w)
  ) cycle_counter_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .count_en (count_en),
    .count    (cycle)
  );

  instr_classifier instr_classifier_i (
    .instr    (instr),
    .iclass   (iclass),
    .rd       (rd),
    .rd_valid (rd_valid)
  );

  ex_slot ex_slot_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .ex_load  (ex_load),
    .ex_busy  (ex_busy),
    .pc       (pc),
    .instr    (instr),
    .cycle    (cycle),
    .iclass   (iclass),
    .rd       (rd),
    .rd_valid (rd_valid),
    .ex_wr    (ex_wr),
    .ex_mem   (ex_mem),
    .ex_next  (ex_next)
  );

  retire_slot retire_slot_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_load     (wb_load),
    .wb_busy     (wb_busy),
    .emit_ex     (emit_ex),
    .emit_wb     (emit_wb),
    .ex_next     (ex_next),
    .wb_wr       (wb_wr),
    .trace_valid (trace_valid),
    .trace_rec   (trace_rec)
  );

endmodule

//--- testbench/tb_checker.sv
// trace checker
// reference model of EX/WB retirement, compares every trace record

module tb_checker (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fetch_enable,
  input  logic [31:0]           pc,
  input  logic [31:0]           instr,
  input  logic                  id_valid,
  input  logic                  is_decoding,
  input  logic                  ex_valid,
  input  trace_pkg::reg_wr_t    ex_wr,
  input  trace_pkg::mem_req_t   ex_mem,
  input  logic                  wb_bypass,
  input  logic                  wb_valid,
  input  trace_pkg::reg_wr_t    wb_wr,
  input  logic                  trace_valid,
  input  trace_pkg::trace_rec_t trace_rec,
  output int                    error_count,
  output int                    missing_count,
  output int                    unexpected_count,
  output int                    record_count,
  output logic                  model_idle
);

  import trace_pkg::*;

  logic               running   = 1'b0;
  logic [cycle_w-1:0] cyc_count = '0;
  logic               ex_full   = 1'b0;
  logic               wb_full   = 1'b0;
  logic               exp_valid = 1'b0;
  trace_rec_t         ex_rec;
  trace_rec_t         wb_rec;
  trace_rec_t         exp_rec;
  // field mismatches and illegal stimulus sequences
  int                 compare_errors;
  int                 rule_errors;

  initial begin
    compare_errors   = 0;
    rule_errors      = 0;
    missing_count    = 0;
    unexpected_count = 0;
    record_count     = 0;
  end

  assign error_count = compare_errors + rule_errors;
  assign model_idle  = !ex_full && !wb_full && !exp_valid;

  ////////////////////////////////////////////////////////////////////////////
  // classification rules
  ////////////////////////////////////////////////////////////////////////////

  function automatic iclass_e class_of(logic [31:0] word);
    logic [2:0] f3;
    f3 = word[14:12];
    case (word[6:0])
      opcode_lui:    return class_u;
      opcode_auipc:  return class_u;
      opcode_jal:    return class_j;
      opcode_jalr:   return class_i;
      opcode_opimm:  return class_i;
      opcode_branch: return class_b;
      opcode_op:     return class_r;
      opcode_system: return class_system;
      opcode_fence:  return class_fence;
      opcode_load:   return (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) ? class_load : class_invalid;
      opcode_store:  return (f3 inside {3'd0, 3'd1, 3'd2}) ? class_s : class_invalid;
      default:       return class_invalid;
    endcase
  endfunction

  function automatic trace_rec_t new_record(logic [31:0] word, logic [31:0] addr);
    trace_rec_t r;
    iclass_e    cls;
    cls        = class_of(word);
    r          = '0;
    r.cycle    = cyc_count;
    r.pc       = addr;
    r.instr    = word;
    r.iclass   = cls;
    r.rd       = word[11:7];
    r.rd_valid = (cls inside {class_u, class_j, class_i, class_r, class_load, class_system})
                 && (word[11:7] != 5'd0);
    return r;
  endfunction

  // a write counts only for an instruction with a real destination
  function automatic trace_rec_t with_reg_write(trace_rec_t rec, reg_wr_t wr);
    trace_rec_t r;
    r = rec;
    if (wr.we && r.rd_valid && wr.addr == r.rd) begin
      r.rd_seen  = 1'b1;
      r.rd_wdata = wr.wdata;
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // model step on every rising edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : model_step
    trace_rec_t ex_upd;
    trace_rec_t wb_upd;
    logic       leave;
    logic       retire;
    logic       capture;
    if (!rst_n) begin
      running   = 1'b0;
      cyc_count = '0;
      ex_full   = 1'b0;
      wb_full   = 1'b0;
      exp_valid = 1'b0;
    end else begin
      ex_upd = with_reg_write(ex_rec, ex_wr);
      if (!ex_upd.mem_valid && ex_mem.req && ex_mem.gnt) begin
        ex_upd.mem_valid = 1'b1;
        ex_upd.mem_we    = ex_mem.we;
        ex_upd.mem_addr  = ex_mem.addr;
      end
      wb_upd  = with_reg_write(wb_rec, wb_wr);
      retire  = wb_full && wb_valid;
      leave   = ex_full && (ex_valid || wb_bypass);
      capture = running && id_valid && is_decoding;
      if (leave && wb_bypass && retire) begin
        rule_errors++;
        $display("stimulus retired from EX and WB in one cycle at t=%0t", $time);
      end
      if (capture && ex_full && !leave) begin
        rule_errors++;
        $display("stimulus captured into a held EX slot at t=%0t", $time);
      end
      if (leave && !wb_bypass && wb_full && !retire) begin
        rule_errors++;
        $display("stimulus moved an entry into a held WB slot at t=%0t", $time);
      end
      exp_valid = 1'b0;
      if (retire) begin
        exp_valid = 1'b1;
        exp_rec   = wb_upd;
      end
      if (leave && wb_bypass) begin
        exp_valid = 1'b1;
        exp_rec   = ex_upd;
      end
      if (leave && !wb_bypass) begin
        wb_rec  = ex_upd;
        wb_full = 1'b1;
      end else if (retire) begin
        wb_full = 1'b0;
      end else if (wb_full) begin
        wb_rec = wb_upd;
      end
      if (capture) begin
        ex_rec  = new_record(instr, pc);
        ex_full = 1'b1;
      end else if (leave) begin
        ex_full = 1'b0;
      end else if (ex_full) begin
        ex_rec = ex_upd;
      end
      if (running) begin
        cyc_count = cyc_count + 32'd1;
      end else if (fetch_enable) begin
        running = 1'b1;
      end
    end
  end

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      compare_errors++;
      $display("ERROR t=%0t trace_rec.%s: got %h expected %h", $time, name, got, want);
    end
  endtask

  // outputs settle after the rising edge, so compare in the low phase
  always @(negedge clk) begin
    if (trace_valid !== exp_valid) begin
      $display("ERROR t=%0t trace_valid: got %b expected %b", $time, trace_valid, exp_valid);
      if (exp_valid) begin
        missing_count++;
      end else begin
        unexpected_count++;
      end
    end else if (exp_valid) begin
      record_count++;
      check_field("cycle", trace_rec.cycle, exp_rec.cycle);
      check_field("pc", trace_rec.pc, exp_rec.pc);
      check_field("instr", trace_rec.instr, exp_rec.instr);
      check_field("iclass", 32'(trace_rec.iclass), 32'(exp_rec.iclass));
      check_field("rd", 32'(trace_rec.rd), 32'(exp_rec.rd));
      check_field("rd_valid", 32'(trace_rec.rd_valid), 32'(exp_rec.rd_valid));
      check_field("rd_seen", 32'(trace_rec.rd_seen), 32'(exp_rec.rd_seen));
      check_field("rd_wdata", trace_rec.rd_wdata, exp_rec.rd_wdata);
      check_field("mem_valid", 32'(trace_rec.mem_valid), 32'(exp_rec.mem_valid));
      check_field("mem_we", 32'(trace_rec.mem_we), 32'(exp_rec.mem_we));
      check_field("mem_addr", trace_rec.mem_addr, exp_rec.mem_addr);
    end
  end

endmodule

//--- testbench/tb_top.sv
// tracer testbench
// random core events under the pipeline rules, checked by tb_checker

module tb_top;

  import trace_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        fetch_enable;
  logic [31:0] pc;
  logic [31:0] instr;
  logic        id_valid;
  logic        is_decoding;
  logic        ex_valid;
  logic        wb_bypass;
  logic        wb_valid;
  reg_wr_t     ex_wr;
  reg_wr_t     wb_wr;
  mem_req_t    ex_mem;
  logic        trace_valid;
  trace_rec_t  trace_rec;
  int          error_count;
  int          missing_count;
  int          unexpected_count;
  int          record_count;
  logic        model_idle;

  // generator view of the core pipeline
  logic        running_seen;
  logic        ex_occ;
  logic        wb_occ;
  reg_addr_t   ex_rd;
  reg_addr_t   wb_rd;
  logic [31:0] next_pc;
  logic        timed_out;
  logic [31:0] rng_state = 32'd15704;
  logic [6:0]  opcode_list [0:10] = '{opcode_lui, opcode_auipc, opcode_jal, opcode_jalr,
                                      opcode_branch, opcode_load, opcode_store, opcode_opimm,
                                      opcode_op, opcode_system, opcode_fence};

  trace_top trace_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_enable (fetch_enable),
    .pc           (pc),
    .instr        (instr),
    .id_valid     (id_valid),
    .is_decoding  (is_decoding),
    .ex_valid     (ex_valid),
    .ex_wr        (ex_wr),
    .ex_mem       (ex_mem),
    .wb_bypass    (wb_bypass),
    .wb_valid     (wb_valid),
    .wb_wr        (wb_wr),
    .trace_valid  (trace_valid),
    .trace_rec    (trace_rec)
  );

  tb_checker tb_checker_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .fetch_enable     (fetch_enable),
    .pc               (pc),
    .instr            (instr),
    .id_valid         (id_valid),
    .is_decoding      (is_decoding),
    .ex_valid         (ex_valid),
    .ex_wr            (ex_wr),
    .ex_mem           (ex_mem),
    .wb_bypass        (wb_bypass),
    .wb_valid         (wb_valid),
    .wb_wr            (wb_wr),
    .trace_valid      (trace_valid),
    .trace_rec        (trace_rec),
    .error_count      (error_count),
    .missing_count    (missing_count),
    .unexpected_count (unexpected_count),
    .record_count     (record_count),
    .model_idle       (model_idle)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // random helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic chance(input logic [31:0] pct);
    return (xorshift32() % 32'd100) < pct;
  endfunction

  // every class opcode plus fully random words
  function automatic logic [31:0] pick_instr();
    logic [31:0] word;
    logic [31:0] sel;
    word = xorshift32();
    sel  = xorshift32() % 32'd14;
    if (sel < 32'd11) begin
      word[6:0] = opcode_list[sel[3:0]];
    end
    if (chance(15)) begin
      word[11:7] = 5'd0;
    end
    return word;
  endfunction

  task automatic drive_idle();
    id_valid    = 1'b0;
    is_decoding = 1'b0;
    ex_valid    = 1'b0;
    wb_bypass   = 1'b0;
    wb_valid    = 1'b0;
    ex_wr       = '0;
    wb_wr       = '0;
    ex_mem      = '0;
  endtask

  // one cycle of legal core events, driven on the falling edge
  task automatic drive_random(input logic allow_capture);
    logic        retire_wb;
    logic        leave;
    logic        bypass;
    logic        capture;
    logic [31:0] r;
    wb_valid  = chance(40);
    retire_wb = wb_occ && wb_valid;
    leave     = 1'b0;
    bypass    = 1'b0;
    if (ex_occ && chance(45)) begin
      bypass = chance(35);
      if (bypass && retire_wb) begin
        bypass = 1'b0;
      end
      if (!bypass && wb_occ && !retire_wb) begin
        bypass = 1'b1;
      end
      leave = 1'b1;
    end
    ex_valid  = leave ? (!bypass || chance(50)) : (!ex_occ && chance(50));
    wb_bypass = leave ? bypass : (!ex_occ && chance(30));
    capture   = allow_capture && running_seen && (!ex_occ || leave) && chance(60);
    instr     = pick_instr();
    if (capture) begin
      id_valid    = 1'b1;
      is_decoding = 1'b1;
      pc          = next_pc;
      next_pc     = next_pc + 32'd4;
    end else begin
      id_valid    = chance(50);
      is_decoding = running_seen ? (!id_valid && chance(50)) : chance(50);
      pc          = xorshift32();
    end
    r = xorshift32();
    ex_wr.we    = r[30];
    ex_wr.addr  = (ex_occ && r[31]) ? ex_rd : r[4:0];
    ex_wr.wdata = xorshift32();
    r = xorshift32();
    ex_mem.req  = r[0];
    ex_mem.gnt  = r[1];
    ex_mem.we   = r[2];
    ex_mem.addr = xorshift32();
    r = xorshift32();
    wb_wr.we    = r[30];
    wb_wr.addr  = (wb_occ && r[31]) ? wb_rd : r[4:0];
    wb_wr.wdata = xorshift32();
    // occupancy after the coming edge
    if (leave && !bypass) begin
      wb_rd  = ex_rd;
      wb_occ = 1'b1;
    end else if (retire_wb) begin
      wb_occ = 1'b0;
    end
    if (capture) begin
      ex_rd  = instr[11:7];
      ex_occ = 1'b1;
    end else if (leave) begin
      ex_occ = 1'b0;
    end
    running_seen = running_seen || fetch_enable;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int          cycle_idx;
    int          wait_cycles;
    logic [31:0] start_delay;
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    pc           = '0;
    instr        = '0;
    drive_idle();
    running_seen = 1'b0;
    ex_occ       = 1'b0;
    wb_occ       = 1'b0;
    ex_rd        = '0;
    wb_rd        = '0;
    next_pc      = 32'h0000_1000;
    timed_out    = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n       = 1'b1;
    start_delay = 32'd4 + (xorshift32() % 32'd16);
    for (cycle_idx = 0; cycle_idx < 4000; cycle_idx++) begin
      fetch_enable = (32'(cycle_idx) >= start_delay);
      drive_random(1'b1);
      @(negedge clk);
    end
    // let both slots drain without new captures
    wait_cycles = 0;
    while ((ex_occ || wb_occ) && wait_cycles < 200) begin
      drive_random(1'b0);
      @(negedge clk);
      wait_cycles++;
    end
    if (ex_occ || wb_occ) begin
      timed_out = 1'b1;
      $display("timed out draining the EX and WB slots");
    end
    drive_idle();
    wait_cycles = 0;
    while (!(model_idle && !trace_valid) && wait_cycles < 10) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (!(model_idle && !trace_valid)) begin
      timed_out = 1'b1;
      $display("timed out waiting for the last trace record");
    end
    $display("errors %0d, missing strobes %0d, unexpected strobes %0d, records %0d",
             error_count, missing_count, unexpected_count, record_count);
    if (error_count == 0 && missing_count == 0 && unexpected_count == 0 &&
        !timed_out && record_count > 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- trace_top.f
logic/trace_pkg.sv
logic/trace_ctrl.sv
logic/cycle_counter.sv
logic/instr_classifier.sv
logic/ex_slot.sv
logic/retire_slot.sv
logic/trace_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_top
FILELIST  = trace_top.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
